//--- Bender.yml
package:
  name: decompress

sources:
  # RTL, the package comes first
  - include_dirs:
      - hw
    files:
      - hw/decompress_pkg.sv
      - hw/piso_multi.sv
      - hw/decompress_lanes.sv
      - hw/decompress_ctrl.sv
      - hw/decompress_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/decompress_tb.sv

//--- decompress_top.f
+incdir+hw
hw/decompress_pkg.sv
hw/piso_multi.sv
hw/decompress_lanes.sv
hw/decompress_ctrl.sv
hw/decompress_top.sv
verif/decompress_tb.sv

//--- hw/decompress_ctrl.sv
`include "decompress_defines.svh"

module decompress_ctrl (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  logic                        start_i,
    input  logic [2:0]                  num_poly_i,
    input  logic [`DCMP_ADDR_W-1:0]     dest_base_i,
    input  logic                        wr_valid_i,
    output decompress_pkg::mem_wr_req_t wr_req_o,
    output logic                        last_o
);

    localparam int unsigned WR_PER_POLY = `DCMP_N / `DCMP_COEFF_PER_CLK;
    // Up to seven polynomials fit in the num_poly field
    localparam int unsigned CNT_W = $clog2(7 * WR_PER_POLY + 1);

    logic [CNT_W-1:0]        wr_total;
    logic [CNT_W-1:0]        wr_cnt_q;
    logic [`DCMP_ADDR_W-1:0] wr_addr_q;
    logic                    last_q;

    assign wr_total = CNT_W'(num_poly_i) * CNT_W'(WR_PER_POLY);

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            wr_addr_q <= '0;
            wr_cnt_q  <= '0;
            last_q    <= 1'b0;
        end else if (start_i) begin
            wr_addr_q <= dest_base_i;
            wr_cnt_q  <= '0;
            last_q    <= 1'b0;
        end else begin
            if (wr_valid_i) begin
                wr_addr_q <= wr_addr_q + `DCMP_ADDR_W'(1);
                wr_cnt_q  <= wr_cnt_q + CNT_W'(1);
            end
            // Flag lands one cycle after the final write
            last_q <= wr_valid_i && (wr_cnt_q == wr_total - CNT_W'(1));
        end
    end

    assign wr_req_o.wr_en = wr_valid_i;
    assign wr_req_o.addr  = wr_addr_q;
    assign last_o         = last_q;

    // Buffer must run dry exactly at the job's write count
    a_no_extra_write: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        wr_valid_i |-> (wr_cnt_q < wr_total)
    ) else $error("decompress_ctrl: write beyond job total");

endmodule

//--- hw/decompress_defines.svh
`ifndef DECOMPRESS_DEFINES_SVH
`define DECOMPRESS_DEFINES_SVH

// Memory address width shared by source and destination
`define DCMP_ADDR_W 15

// Source memory returns one word of this width per read
`define DCMP_RD_W 64

// Coefficients written per clock
`define DCMP_COEFF_PER_CLK 4

// Width of a decompressed coefficient
`define DCMP_COEFF_W 12

// Destination lane width, upper bits are zero padding
`define DCMP_LANE_W 24

// ML-KEM modulus
`define DCMP_Q 3329

// Coefficients per polynomial
`define DCMP_N 256

// Re-chunking buffer width
// One full read word plus the widest group (4 x 12 bits)
`define DCMP_PISO_W 112

`endif

//--- hw/decompress_lanes.sv
`include "decompress_defines.svh"

module decompress_lanes (
    input  decompress_pkg::decompress_mode_t mode_i,
    input  decompress_pkg::group_t           group_i,
    output decompress_pkg::wr_data_t         data_o
);
    import decompress_pkg::*;

    localparam int unsigned NC     = `DCMP_COEFF_PER_CLK;
    localparam int unsigned CW     = `DCMP_COEFF_W;
    // 12-bit field times a 12-bit modulus plus rounding fits in 24 bits
    localparam int unsigned PROD_W = 2 * CW;

    logic [3:0]                 d_bits;
    logic [CW-1:0]              field_mask;
    logic [PROD_W-1:0]          round_c;
    logic [NC-1:0][CW-1:0]      field;
    logic [NC-1:0][PROD_W-1:0]  prod;
    coeff_vec_t                 coeff;

    assign d_bits     = mode_bits(mode_i);
    assign field_mask = CW'((PROD_W'(1) << d_bits) - PROD_W'(1));
    // Half an LSB of the output, 2^(d-1)
    assign round_c    = PROD_W'(1) << (d_bits - 4'd1);

    for (genvar i = 0; i < NC; i++) begin : g_lane
        // Coefficients are packed LSB first, d bits each
        assign field[i] = CW'(group_i >> (i * d_bits)) & field_mask;

        assign prod[i]  = PROD_W'(field[i]) * PROD_W'(`DCMP_Q) + round_c;

        // round(x * q / 2^d)
        assign coeff[i] = CW'(prod[i] >> d_bits);

        assign data_o[i] = `DCMP_LANE_W'(coeff[i]);
    end

endmodule

//--- hw/decompress_pkg.sv
`include "decompress_defines.svh"

package decompress_pkg;

    // Compression width d selected per job
    typedef enum logic [1:0] {
        MODE_D1  = 2'd0,
        MODE_D5  = 2'd1,
        MODE_D11 = 2'd2,
        MODE_D12 = 2'd3
    } decompress_mode_t;

    // Destination write port
    typedef struct packed {
        logic                    wr_en;
        logic [`DCMP_ADDR_W-1:0] addr;
    } mem_wr_req_t;

    // Four decompressed coefficients
    typedef logic [`DCMP_COEFF_PER_CLK-1:0][`DCMP_COEFF_W-1:0] coeff_vec_t;

    // Four zero-padded memory lanes, 96 bits
    typedef logic [`DCMP_COEFF_PER_CLK-1:0][`DCMP_LANE_W-1:0] wr_data_t;

    // Widest buffer group, only the low 4*d bits are meaningful
    typedef logic [`DCMP_COEFF_PER_CLK*`DCMP_COEFF_W-1:0] group_t;

    // Bits per compressed coefficient for a mode
    function automatic logic [3:0] mode_bits(decompress_mode_t mode);
        logic [3:0] d;
        case (mode)
            MODE_D1:  d = 4'd1;
            MODE_D5:  d = 4'd5;
            MODE_D11: d = 4'd11;
            MODE_D12: d = 4'd12;
            default:  d = 4'd12;
        endcase
        return d;
    endfunction

endpackage

//--- hw/decompress_top.sv
`include "decompress_defines.svh"

module decompress_top (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize_i,

    // Job setup, held stable until done
    input  logic                             start_i,
    input  decompress_pkg::decompress_mode_t mode_i,
    input  logic [2:0]                       num_poly_i,
    input  logic [`DCMP_ADDR_W-1:0]          src_base_i,
    input  logic [`DCMP_ADDR_W-1:0]          dest_base_i,

    // Source memory, data returns one cycle after rd_en
    output logic                             rd_en_o,
    output logic [`DCMP_ADDR_W-1:0]          rd_addr_o,
    input  logic [`DCMP_RD_W-1:0]            rd_data_i,

    // Destination memory, always accepts
    output decompress_pkg::mem_wr_req_t      wr_req_o,
    output decompress_pkg::wr_data_t         wr_data_o,

    output logic                             done_o
);
    import decompress_pkg::*;

    logic                    busy_q;
    logic                    piso_valid_q;
    logic                    piso_hold;
    logic                    grp_valid;
    group_t                  group;
    logic                    wr_last;
    logic [3:0]              d_bits;
    logic [`DCMP_ADDR_W-1:0] rd_addr_q;
    logic [`DCMP_ADDR_W-1:0] rd_words;
    logic                    read_done;

    assign done_o = busy_q & wr_last;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            busy_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
        end else if (done_o) begin
            busy_q <= 1'b0;
        end
    end

    // Each polynomial takes N*d bits of source, d*4 words of 64 bits
    assign d_bits    = mode_bits(mode_i);
    assign rd_words  = `DCMP_ADDR_W'(num_poly_i) * `DCMP_ADDR_W'(d_bits)
                     * `DCMP_ADDR_W'(`DCMP_N / `DCMP_RD_W);
    assign read_done = (rd_addr_q == src_base_i + rd_words);

    assign rd_en_o   = busy_q & ~read_done & ~piso_hold;
    assign rd_addr_o = rd_addr_q;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            rd_addr_q <= '0;
        end else if (start_i) begin
            rd_addr_q <= src_base_i;
        end else if (rd_en_o) begin
            rd_addr_q <= rd_addr_q + `DCMP_ADDR_W'(1);
        end
    end

    // Marks the cycle rd_data_i carries a requested word
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            piso_valid_q <= 1'b0;
        end else begin
            piso_valid_q <= rd_en_o;
        end
    end

    piso_multi u_piso (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .valid_i   (piso_valid_q),
        .data_i    (rd_data_i),
        .hold_o    (piso_hold),
        .valid_o   (grp_valid),
        .data_o    (group)
    );

    // Same-cycle path from group to write data
    decompress_lanes u_lanes (
        .mode_i  (mode_i),
        .group_i (group),
        .data_o  (wr_data_o)
    );

    decompress_ctrl u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .num_poly_i  (num_poly_i),
        .dest_base_i (dest_base_i),
        .wr_valid_i  (grp_valid),
        .wr_req_o    (wr_req_o),
        .last_o      (wr_last)
    );

    // Idle engine is silent on both ports, buffer must be drained by done
    a_idle_quiet: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        !busy_q |-> (!rd_en_o && !wr_req_o.wr_en)
    ) else $error("decompress_top: memory strobe while idle");

endmodule

//--- hw/piso_multi.sv
`include "decompress_defines.svh"

module piso_multi (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize_i,
    input  decompress_pkg::decompress_mode_t mode_i,
    input  logic                             valid_i,
    input  logic [`DCMP_RD_W-1:0]            data_i,
    output logic                             hold_o,
    output logic                             valid_o,
    output decompress_pkg::group_t           data_o
);
    import decompress_pkg::*;

    localparam int unsigned BUF_W  = `DCMP_PISO_W;
    localparam int unsigned CNT_W  = $clog2(BUF_W + 1);
    // One spare bit so an overflowing fill stays visible
    localparam int unsigned SUM_W  = CNT_W + 1;
    localparam int unsigned GRP_W  = `DCMP_COEFF_PER_CLK * `DCMP_COEFF_W;
    localparam int unsigned GBIT_W = $clog2(GRP_W + 1);

    logic [BUF_W-1:0]  shift_q;
    logic [BUF_W-1:0]  shift_kept;
    logic [BUF_W-1:0]  shift_next;
    logic [CNT_W-1:0]  fill_q;
    logic [CNT_W-1:0]  fill_kept;
    logic [SUM_W-1:0]  fill_sum;
    logic [CNT_W-1:0]  fill_next;
    logic [GBIT_W-1:0] grp_bits;
    logic              valid_q;

    // 4*d bits leave per group
    assign grp_bits = GBIT_W'(mode_bits(mode_i)) * GBIT_W'(`DCMP_COEFF_PER_CLK);

    // Drop the group being emitted this cycle from the bottom
    always_comb begin
        if (valid_q) begin
            shift_kept = shift_q >> grp_bits;
            fill_kept  = fill_q - CNT_W'(grp_bits);
        end else begin
            shift_kept = shift_q;
            fill_kept  = fill_q;
        end
    end

    // New word lands directly above whatever remains
    always_comb begin
        shift_next = shift_kept;
        fill_sum   = SUM_W'(fill_kept);
        if (valid_i) begin
            shift_next = shift_kept | (BUF_W'(data_i) << fill_kept);
            fill_sum   = SUM_W'(fill_kept) + SUM_W'(`DCMP_RD_W);
        end
    end

    assign fill_next = CNT_W'(fill_sum);

    // Stall reads unless a full word still fits after this cycle's update,
    // so the word requested now is always captured next cycle
    assign hold_o = fill_next > CNT_W'(BUF_W - `DCMP_RD_W);

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            shift_q <= '0;
            fill_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            shift_q <= shift_next;
            fill_q  <= fill_next;
            // Group ready as soon as 4*d bits sit in the buffer
            valid_q <= fill_next >= CNT_W'(grp_bits);
        end
    end

    assign valid_o = valid_q;
    assign data_o  = shift_q[GRP_W-1:0];

    // Read pacing from the top must never overrun the buffer
    a_fill_bound: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        fill_sum <= SUM_W'(BUF_W)
    ) else $error("piso_multi: fill count exceeds buffer width");

endmodule

//--- verif/decompress_tb.sv
`include "decompress_defines.svh"

module decompress_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import decompress_pkg::*;

    localparam int unsigned SRC_DEPTH  = 1024;
    localparam int unsigned NUM_JOBS   = 9;
    localparam int unsigned DONE_LIMIT = 4000;
    localparam int unsigned MAX_WR     = 4 * `DCMP_N / `DCMP_COEFF_PER_CLK;

    // One row of the job table, zero_after of 0 means run to done
    typedef struct packed {
        decompress_mode_t        mode;
        logic [2:0]              num_poly;
        logic [`DCMP_ADDR_W-1:0] src_base;
        logic [`DCMP_ADDR_W-1:0] dest_base;
        logic [15:0]             zero_after;
    } job_t;

    typedef enum logic [1:0] {MON_IDLE, MON_ACTIVE, MON_SKIP} mon_state_t;

    logic                    clk = 1'b0;
    logic                    reset_n;
    logic                    zeroize_i;
    logic                    start_i;
    decompress_mode_t        mode_i;
    logic [2:0]              num_poly_i;
    logic [`DCMP_ADDR_W-1:0] src_base_i;
    logic [`DCMP_ADDR_W-1:0] dest_base_i;
    logic                    rd_en_o;
    logic [`DCMP_ADDR_W-1:0] rd_addr_o;
    logic [`DCMP_RD_W-1:0]   rd_data_i;
    mem_wr_req_t             wr_req_o;
    wr_data_t                wr_data_o;
    logic                    done_o;

    logic [`DCMP_RD_W-1:0]   src_mem [SRC_DEPTH];
    wr_data_t                exp_data [MAX_WR];
    job_t                    jobs [NUM_JOBS];
    job_t                    cur_job;
    mon_state_t              mon_state;
    int unsigned             rd_total;
    int unsigned             wr_total;
    int unsigned             rd_seen;
    int unsigned             wr_seen;
    logic                    final_wr_prev;
    logic                    final_wr_now;
    logic                    done_seen;
    logic                    rd_pend;
    logic [`DCMP_ADDR_W-1:0] rd_pend_addr;

    decompress_top dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .mode_i      (mode_i),
        .num_poly_i  (num_poly_i),
        .src_base_i  (src_base_i),
        .dest_base_i (dest_base_i),
        .rd_en_o     (rd_en_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_i   (rd_data_i),
        .wr_req_o    (wr_req_o),
        .wr_data_o   (wr_data_o),
        .done_o      (done_o)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic job_t make_job(input decompress_mode_t mode, input int unsigned np,
                                      input int unsigned src, input int unsigned dest,
                                      input int unsigned zafter);
        job_t j;
        j.mode       = mode;
        j.num_poly   = 3'(np);
        j.src_base   = `DCMP_ADDR_W'(src);
        j.dest_base  = `DCMP_ADDR_W'(dest);
        j.zero_after = 16'(zafter);
        return j;
    endfunction

    // Two jobs are cut short by zeroize, each followed by a clean job
    task automatic load_jobs();
        jobs[0] = make_job(MODE_D1,  1,   0, 'h0100,  0);
        jobs[1] = make_job(MODE_D5,  2,  10, 'h0200,  0);
        jobs[2] = make_job(MODE_D11, 3,  50, 'h0400,  0);
        jobs[3] = make_job(MODE_D12, 4, 200, 'h7f00,  0);
        jobs[4] = make_job(MODE_D11, 2, 400, 'h1000, 40);
        jobs[5] = make_job(MODE_D11, 2, 400, 'h1000,  0);
        jobs[6] = make_job(MODE_D5,  1, 600, 'h2000,  3);
        jobs[7] = make_job(MODE_D1,  4, 700, 'h3000,  0);
        jobs[8] = make_job(MODE_D12, 1, 900, 'h0040,  0);
    endtask

    // Source stream is read LSB first, d bits per coefficient
    task automatic build_expected(input job_t j);
        int unsigned d;
        int unsigned c;
        int unsigned b;
        int unsigned bitpos;
        int unsigned x;
        int unsigned r;
        logic [`DCMP_RD_W-1:0] word;
        d = mode_bits(j.mode);
        for (c = 0; c < j.num_poly * `DCMP_N; c++) begin
            x = 0;
            for (b = 0; b < d; b++) begin
                bitpos = c * d + b;
                word   = src_mem[j.src_base + bitpos / `DCMP_RD_W];
                x      = x | (int'(word[bitpos % `DCMP_RD_W]) << b);
            end
            r = (x * `DCMP_Q + (1 << (d - 1))) >> d;
            exp_data[c / 4][c % 4] = {12'd0, 12'(r)};
        end
    endtask

    task automatic check_read(input logic [`DCMP_ADDR_W-1:0] addr);
        logic [`DCMP_ADDR_W-1:0] exp_addr;
        exp_addr = cur_job.src_base + `DCMP_ADDR_W'(rd_seen);
        if (rd_seen >= rd_total)
            abort_run($sformatf("[FAIL] time %0t: read %0d beyond total %0d",
                                $time, rd_seen, rd_total));
        if (addr !== exp_addr)
            abort_run($sformatf("[FAIL] time %0t: read address %h, expected %h",
                                $time, addr, exp_addr));
    endtask

    task automatic check_write(input mem_wr_req_t req, input wr_data_t data);
        logic [`DCMP_ADDR_W-1:0] exp_addr;
        exp_addr = cur_job.dest_base + `DCMP_ADDR_W'(wr_seen);
        if (wr_seen >= wr_total)
            abort_run($sformatf("[FAIL] time %0t: write %0d beyond total %0d",
                                $time, wr_seen, wr_total));
        if (req.addr !== exp_addr)
            abort_run($sformatf("[FAIL] time %0t: write address %h, expected %h",
                                $time, req.addr, exp_addr));
        if (data !== exp_data[wr_seen])
            abort_run($sformatf("[FAIL] time %0t: write %0d data %h, expected %h",
                                $time, wr_seen, data, exp_data[wr_seen]));
    endtask

    task automatic check_done(input int unsigned count);
        if (count != wr_total)
            abort_run($sformatf("[FAIL] time %0t: done after %0d writes, expected %0d",
                                $time, count, wr_total));
        if (!final_wr_prev)
            abort_run($sformatf("[FAIL] time %0t: done not one cycle after final write",
                                $time));
        if (rd_seen != rd_total)
            abort_run($sformatf("[FAIL] time %0t: %0d reads at done, expected %0d",
                                $time, rd_seen, rd_total));
    endtask

    // Outputs are sampled mid-cycle, well away from the edge
    always @(negedge clk) begin
        rd_pend      = (rd_en_o === 1'b1);
        rd_pend_addr = rd_addr_o;
        if (reset_n && mon_state == MON_IDLE) begin
            if (rd_en_o !== 1'b0 || wr_req_o.wr_en !== 1'b0 || done_o !== 1'b0)
                abort_run("A read, write or done strobe was active while no job was running");
        end else if (reset_n && mon_state == MON_ACTIVE) begin
            if ($isunknown({rd_en_o, wr_req_o.wr_en, done_o}))
                abort_run("A read, write or done strobe was unknown during a job");
            if (rd_en_o) begin
                check_read(rd_addr_o);
                rd_seen++;
            end
            final_wr_now = 1'b0;
            if (wr_req_o.wr_en) begin
                check_write(wr_req_o, wr_data_o);
                final_wr_now = (wr_seen == wr_total - 1);
                wr_seen++;
            end
            if (done_o) begin
                check_done(wr_seen);
                done_seen = 1'b1;
                mon_state = MON_IDLE;
            end
            final_wr_prev = final_wr_now;
        end
    end

    // Registered source memory, data one cycle after rd_en
    always @(posedge clk) begin
        #2;
        if (rd_pend)
            rd_data_i = src_mem[rd_pend_addr];
    end

    task automatic run_job(input job_t j);
        int unsigned cycles;
        build_expected(j);
        cur_job       = j;
        rd_total      = j.num_poly * mode_bits(j.mode) * 4;
        wr_total      = j.num_poly * (`DCMP_N / `DCMP_COEFF_PER_CLK);
        rd_seen       = 0;
        wr_seen       = 0;
        final_wr_prev = 1'b0;
        done_seen     = 1'b0;
        @(posedge clk);
        #2;
        mode_i      = j.mode;
        num_poly_i  = j.num_poly;
        src_base_i  = j.src_base;
        dest_base_i = j.dest_base;
        start_i     = 1'b1;
        mon_state   = MON_ACTIVE;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        if (j.zero_after != 0) begin
            repeat (j.zero_after) @(posedge clk);
            #2;
            zeroize_i = 1'b1;
            mon_state = MON_SKIP;
            @(posedge clk);
            #2;
            zeroize_i = 1'b0;
            mon_state = MON_IDLE;
        end else begin
            cycles = 0;
            while (!done_seen) begin
                @(posedge clk);
                cycles++;
                if (cycles > DONE_LIMIT)
                    abort_run($sformatf("Timeout: done never came for job at source %h",
                                        j.src_base));
            end
        end
        // Engine must stay quiet until the next start
        repeat (6) @(posedge clk);
    endtask

    initial begin
        int unsigned i;
        int unsigned k;
        void'($urandom(32'h0a4fab8f));
        for (i = 0; i < SRC_DEPTH; i++)
            src_mem[i] = {$urandom, $urandom};
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        start_i     = 1'b0;
        mode_i      = MODE_D1;
        num_poly_i  = '0;
        src_base_i  = '0;
        dest_base_i = '0;
        rd_data_i   = '0;
        rd_pend     = 1'b0;
        mon_state   = MON_IDLE;
        load_jobs();
        repeat (2) @(posedge clk);
        #2;
        reset_n = 1'b1;
        // Idle after reset, strobes checked by the monitor
        repeat (8) @(posedge clk);
        for (k = 0; k < NUM_JOBS; k++)
            run_job(jobs[k]);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
